/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam logic [6 : 0] opcode_op     = 7'b0110011;
  localparam logic [6 : 0] opcode_op_imm = 7'b0010011;
  localparam logic [6 : 0] opcode_lui    = 7'b0110111;

  typedef enum logic [3 : 0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt
  } alu_op_e;

  typedef struct packed {
    logic [6 : 0] funct7;
    logic [4 : 0] rs2;
    logic [4 : 0] rs1;
    logic [2 : 0] funct3;
    logic [4 : 0] rd;
    logic [6 : 0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11 : 0] imm;
    logic [4 : 0] rs1;
    logic [2 : 0] funct3;
    logic [4 : 0] rd;
    logic [6 : 0] opcode;
  } i_type_t;

  typedef struct packed {
    logic [19 : 0] imm;
    logic [4 : 0] rd;
    logic [6 : 0] opcode;
  } u_type_t;

  // All three views share the rd and opcode positions
  typedef union packed {
    r_type_t r;
    i_type_t i;
    u_type_t u;
  } instr_t;

  typedef struct packed {
    logic valid;
    logic [31 : 0] pc;
    instr_t instr;
  } fetch_out_t;

  typedef struct packed {
    logic valid;
    logic [31 : 0] pc;
    logic [4 : 0] rd;
    logic [4 : 0] rs1;
    logic [4 : 0] rs2;
    logic use_rs1;
    logic use_rs2;
    logic [31 : 0] op1;
    logic [31 : 0] op2;
    alu_op_e alu_op;
    logic illegal;
  } decode_out_t;

  typedef struct packed {
    logic valid;
    logic [31 : 0] pc;
    logic [4 : 0] rd;
    logic [31 : 0] data;
    logic illegal;
  } retire_t;

  typedef struct packed {
    logic enable;
    logic [4 : 0] addr;
    logic [31 : 0] data;
  } reg_write_t;

endpackage

`default_nettype wire

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
#(
  parameter logic [31 : 0] reset_addr = 32'h0
)
(
  input  logic clock,
  input  logic rst,
  input  logic [31 : 0] imemory_rdata,
  input  logic [0 : 0] imemory_ready,
  output logic [0 : 0] imemory_valid,
  output logic [31 : 0] imemory_addr,
  output cpu_pkg::fetch_out_t fetch_out
);

  logic [31 : 0] pc;
  logic accept;

  assign accept = imemory_valid && imemory_ready;
  assign imemory_addr = pc;

  always_ff @(posedge clock) begin
    if (rst) begin
      imemory_valid <= 1'b0;
      pc <= reset_addr;
    end else begin
      imemory_valid <= 1'b1; // Request stays up for the whole run
      if (accept) begin
        pc <= pc + 32'd4;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      fetch_out.pc <= pc;
      fetch_out.instr <= imemory_rdata;
    end
    if (rst) begin
      fetch_out.valid <= 1'b0;
    end else begin
      fetch_out.valid <= accept; // Bubble while memory holds ready low
    end
  end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
(
  input  logic clock,
  input  logic rst,
  input  cpu_pkg::fetch_out_t fetch_in,
  input  logic [31 : 0] rs1_data,
  input  logic [31 : 0] rs2_data,
  output logic [4 : 0] rs1_addr,
  output logic [4 : 0] rs2_addr,
  output cpu_pkg::decode_out_t decode_out
);
  import cpu_pkg::*;

  instr_t instr;
  decode_out_t decode_next;
  logic [31 : 0] imm_i;
  logic funct7_ok;

  assign instr = fetch_in.instr;
  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;
  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};

  // Only SUB may set funct7 among the supported register forms
  assign funct7_ok = (instr.r.funct7 == 7'b0000000) ||
                     (instr.r.funct7 == 7'b0100000 && instr.r.funct3 == 3'b000);

  always_comb begin
    decode_next.valid = fetch_in.valid;
    decode_next.pc = fetch_in.pc;
    decode_next.rd = instr.r.rd;
    decode_next.rs1 = instr.r.rs1;
    decode_next.rs2 = instr.r.rs2;
    decode_next.use_rs1 = 1'b1;
    decode_next.use_rs2 = 1'b0;
    decode_next.op1 = rs1_data;
    decode_next.op2 = imm_i;
    decode_next.alu_op = alu_add;
    decode_next.illegal = 1'b0;
    case (instr.r.opcode)
      opcode_op: begin
        decode_next.use_rs2 = 1'b1;
        decode_next.op2 = rs2_data;
        decode_next.illegal = !funct7_ok;
        case (instr.r.funct3)
          3'b000: decode_next.alu_op = instr.r.funct7[5] ? alu_sub : alu_add;
          3'b001: decode_next.alu_op = alu_sll;
          3'b010: decode_next.alu_op = alu_slt;
          3'b100: decode_next.alu_op = alu_xor;
          3'b101: decode_next.alu_op = alu_srl;
          3'b110: decode_next.alu_op = alu_or;
          3'b111: decode_next.alu_op = alu_and;
          default: decode_next.illegal = 1'b1; // SLTU is not supported
        endcase
      end
      opcode_op_imm: begin
        case (instr.i.funct3)
          3'b000: decode_next.alu_op = alu_add;
          3'b010: decode_next.alu_op = alu_slt;
          3'b100: decode_next.alu_op = alu_xor;
          3'b110: decode_next.alu_op = alu_or;
          3'b111: decode_next.alu_op = alu_and;
          default: decode_next.illegal = 1'b1; // Shift immediates and SLTIU
        endcase
      end
      opcode_lui: begin
        decode_next.use_rs1 = 1'b0;
        decode_next.op1 = '0;
        decode_next.op2 = {instr.u.imm, 12'h000};
      end
      default: begin
        decode_next.use_rs1 = 1'b0;
        decode_next.illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    decode_out <= decode_next;
    if (rst) begin
      decode_out.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
(
  input  logic clock,
  input  logic rst,
  input  logic [4 : 0] rs1_addr,
  input  logic [4 : 0] rs2_addr,
  input  cpu_pkg::reg_write_t write,
  output logic [31 : 0] rs1_data,
  output logic [31 : 0] rs2_data
);

  logic [31 : 0] regs [1 : 31];

  // A write in the same cycle is seen by the read, which covers distance two
  function automatic logic [31 : 0] read_port(input logic [4 : 0] addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (write.enable && write.addr == addr) begin
      return write.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write.enable && write.addr != 5'd0) begin
      regs[write.addr] <= write.data;
    end
  end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
(
  input  logic clock,
  input  logic rst,
  input  cpu_pkg::decode_out_t decode_in,
  output cpu_pkg::retire_t retire,
  output cpu_pkg::reg_write_t write
);
  import cpu_pkg::*;

  logic retire_writes;
  logic [31 : 0] op1;
  logic [31 : 0] op2;
  logic [31 : 0] result;

  assign retire_writes = retire.valid && !retire.illegal && (retire.rd != 5'd0);

  // Distance one needs the result still sitting in the retire register
  assign op1 = (decode_in.use_rs1 && retire_writes && decode_in.rs1 == retire.rd) ?
               retire.data : decode_in.op1;
  assign op2 = (decode_in.use_rs2 && retire_writes && decode_in.rs2 == retire.rd) ?
               retire.data : decode_in.op2;

  always_comb begin
    case (decode_in.alu_op)
      alu_add: result = op1 + op2;
      alu_sub: result = op1 - op2;
      alu_and: result = op1 & op2;
      alu_or: result = op1 | op2;
      alu_xor: result = op1 ^ op2;
      alu_sll: result = op1 << op2[4 : 0];
      alu_srl: result = op1 >> op2[4 : 0];
      alu_slt: result = {31'b0, $signed(op1) < $signed(op2)};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    retire.pc <= decode_in.pc;
    retire.rd <= decode_in.rd;
    retire.illegal <= decode_in.illegal;
    retire.data <= decode_in.illegal ? '0 : result;
    if (rst) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= decode_in.valid;
    end
  end

  assign write = '{
    enable: retire_writes,
    addr: retire.rd,
    data: retire.data
  };

endmodule

`default_nettype wire

/* source/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu
#(
  parameter logic [31 : 0] reset_addr = 32'h0
)
(
  input  logic clock,
  input  logic rst,
  output logic [0 : 0] imemory_valid,
  output logic [31 : 0] imemory_addr,
  input  logic [31 : 0] imemory_rdata,
  input  logic [0 : 0] imemory_ready,
  output logic [0 : 0] retire_valid,
  output logic [31 : 0] retire_pc,
  output logic [4 : 0] retire_rd,
  output logic [31 : 0] retire_data,
  output logic [0 : 0] retire_illegal
);
  import cpu_pkg::*;

  fetch_out_t fetch_out;
  decode_out_t decode_out;
  retire_t retire;
  reg_write_t reg_write;
  logic [4 : 0] rs1_addr;
  logic [4 : 0] rs2_addr;
  logic [31 : 0] rs1_data;
  logic [31 : 0] rs2_data;

  fetch_stage #(
    .reset_addr (reset_addr)
  ) fetch_stage_comp (
    .clock (clock),
    .rst (rst),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .imemory_valid (imemory_valid),
    .imemory_addr (imemory_addr),
    .fetch_out (fetch_out)
  );

  decode_stage decode_stage_comp (
    .clock (clock),
    .rst (rst),
    .fetch_in (fetch_out),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .decode_out (decode_out)
  );

  register_file register_file_comp (
    .clock (clock),
    .rst (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .write (reg_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_stage execute_stage_comp (
    .clock (clock),
    .rst (rst),
    .decode_in (decode_out),
    .retire (retire),
    .write (reg_write)
  );

  assign retire_valid = retire.valid;
  assign retire_pc = retire.pc;
  assign retire_rd = retire.rd;
  assign retire_data = retire.data;
  assign retire_illegal = retire.illegal;

endmodule

`default_nettype wire

/* dv/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties
(
  input logic clock,
  input logic rst,
  input logic imemory_valid,
  input logic imemory_ready,
  input logic [31 : 0] imemory_addr,
  input logic retire_valid,
  input cpu_pkg::reg_write_t reg_write
);

  quiet_in_reset: assert property (@(posedge clock) rst |=> !imemory_valid && !retire_valid)
    else $error("Request or retire while in reset");

  // The address may only move on an accepted word
  addr_held: assert property (@(posedge clock) disable iff (rst)
    imemory_valid && !imemory_ready |=> $stable(imemory_addr))
    else $error("Fetch address changed while the memory held ready low");

  addr_aligned: assert property (@(posedge clock) disable iff (rst) imemory_addr[1 : 0] == 2'b00)
    else $error("Fetch address is not word aligned");

  no_x0_write: assert property (@(posedge clock) disable iff (rst)
    reg_write.enable |-> reg_write.addr != 5'd0)
    else $error("Register file write enabled for x0");

endmodule

bind cpu cpu_properties u_properties (
  .clock (clock),
  .rst (rst),
  .imemory_valid (imemory_valid),
  .imemory_ready (imemory_ready),
  .imemory_addr (imemory_addr),
  .retire_valid (retire_valid),
  .reg_write (reg_write)
);

`default_nettype wire

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  typedef struct packed {
    logic [31 : 0] word;
    logic [4 : 0] rd;
    logic [31 : 0] data;
    logic illegal;
  } entry_t;

  localparam logic [31 : 0] start_addr = 32'h100;
  localparam logic [31 : 0] nop_word = 32'h00000013; // ADDI x0, x0, 0
  localparam int wait_limit = 200;

  logic clock;
  logic rst;
  logic [0 : 0] imemory_valid;
  logic [31 : 0] imemory_addr;
  logic [31 : 0] imemory_rdata;
  logic [0 : 0] imemory_ready;
  logic [0 : 0] retire_valid;
  logic [31 : 0] retire_pc;
  logic [4 : 0] retire_rd;
  logic [31 : 0] retire_data;
  logic [0 : 0] retire_illegal;

  entry_t program_table[$];
  integer seed = 32'he2f72c35;
  integer rnd;
  int errors;
  int cycles;
  bit timed_out;

  cpu #(
    .reset_addr (start_addr)
  ) u_dut (
    .clock (clock),
    .rst (rst),
    .imemory_valid (imemory_valid),
    .imemory_addr (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .retire_valid (retire_valid),
    .retire_pc (retire_pc),
    .retire_rd (retire_rd),
    .retire_data (retire_data),
    .retire_illegal (retire_illegal)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31 : 0] encode_r(input logic [6 : 0] funct7, input logic [4 : 0] rs2,
                                              input logic [4 : 0] rs1, input logic [2 : 0] funct3,
                                              input logic [4 : 0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31 : 0] encode_i(input logic [11 : 0] imm, input logic [4 : 0] rs1,
                                              input logic [2 : 0] funct3, input logic [4 : 0] rd);
    return {imm, rs1, funct3, rd, 7'b0010011};
  endfunction

  function automatic logic [31 : 0] encode_lui(input logic [19 : 0] imm, input logic [4 : 0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Words past the end of the program read as NOPs
  function automatic logic [31 : 0] fetch_word(input logic [31 : 0] addr);
    logic [31 : 0] index;
    index = (addr - start_addr) >> 2;
    if (addr >= start_addr && index < 32'(program_table.size())) begin
      return program_table[index].word;
    end
    return nop_word;
  endfunction

  task automatic add_entry(input logic [31 : 0] word, input logic [4 : 0] rd,
                           input logic [31 : 0] data, input logic illegal);
    entry_t entry;
    entry.word = word;
    entry.rd = rd;
    entry.data = data;
    entry.illegal = illegal;
    program_table.push_back(entry);
  endtask

  task automatic load_program;
    add_entry(encode_i(12'd100, 5'd0, 3'b000, 5'd1), 5'd1, 32'd100, 1'b0);
    add_entry(encode_i(12'hff9, 5'd0, 3'b000, 5'd2), 5'd2, 32'hfffffff9, 1'b0);
    add_entry(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'd93, 1'b0);
    add_entry(encode_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4), 5'd4, 32'hffffff95, 1'b0);
    add_entry(encode_r(7'h20, 5'd1, 5'd0, 3'b000, 5'd5), 5'd5, 32'hffffff9c, 1'b0);
    add_entry(encode_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 5'd6, 32'h00000060, 1'b0);
    add_entry(encode_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), 5'd7, 32'hfffffffd, 1'b0);
    add_entry(encode_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 5'd8, 32'hffffff9d, 1'b0);
    add_entry(encode_i(12'd20, 5'd0, 3'b000, 5'd9), 5'd9, 32'd20, 1'b0);
    add_entry(encode_r(7'h00, 5'd9, 5'd1, 3'b001, 5'd10), 5'd10, 32'h06400000, 1'b0);
    add_entry(encode_r(7'h00, 5'd9, 5'd2, 3'b101, 5'd11), 5'd11, 32'h00000fff, 1'b0);
    add_entry(encode_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd12), 5'd12, 32'd1, 1'b0);
    add_entry(encode_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd13), 5'd13, 32'd0, 1'b0);
    add_entry(encode_i(12'hfff, 5'd2, 3'b010, 5'd14), 5'd14, 32'd1, 1'b0);
    add_entry(encode_i(12'h0f0, 5'd2, 3'b111, 5'd15), 5'd15, 32'h000000f0, 1'b0);
    add_entry(encode_i(12'h700, 5'd1, 3'b110, 5'd16), 5'd16, 32'h00000764, 1'b0);
    add_entry(encode_i(12'hfff, 5'd1, 3'b100, 5'd17), 5'd17, 32'hffffff9b, 1'b0);
    add_entry(encode_lui(20'habcde, 5'd18), 5'd18, 32'habcde000, 1'b0);
    add_entry(encode_i(12'h123, 5'd18, 3'b000, 5'd19), 5'd19, 32'habcde123, 1'b0);
    add_entry({12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011}, 5'd1, 32'd0, 1'b1); // Load opcode
    add_entry(encode_i(12'd0, 5'd1, 3'b000, 5'd20), 5'd20, 32'd100, 1'b0);
    add_entry(encode_i(12'd5, 5'd1, 3'b000, 5'd0), 5'd0, 32'd105, 1'b0);
    add_entry(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd21), 5'd21, 32'd0, 1'b0);
    add_entry(encode_i(12'd3, 5'd0, 3'b000, 5'd22), 5'd22, 32'd3, 1'b0);
    add_entry(encode_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd23), 5'd23, 32'hfffffff2, 1'b0);
  endtask

  task automatic compare_field(input string field, input logic [31 : 0] got,
                               input logic [31 : 0] expected);
    assert (got == expected) else begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, field, got, expected);
    end
  endtask

  task automatic check_retire(input int index);
    entry_t entry;
    logic [31 : 0] pc_expected;
    entry = program_table[index];
    pc_expected = start_addr + (32'(index) << 2); // Program order, one word each
    compare_field($sformatf("retire %0d pc", index), retire_pc, pc_expected);
    compare_field($sformatf("retire %0d rd", index), {27'b0, retire_rd}, {27'b0, entry.rd});
    compare_field($sformatf("retire %0d data", index), retire_data, entry.data);
    compare_field($sformatf("retire %0d illegal", index), {31'b0, retire_illegal},
                  {31'b0, entry.illegal});
  endtask

  // Memory model with random back-pressure
  always @(negedge clock) begin
    rnd = $random(seed);
    imemory_ready = rnd[9 : 0] < 10'd717; // About 70 percent ready
    imemory_rdata = fetch_word(imemory_addr);
  end

  initial begin
    rst = 1'b1;
    imemory_ready = 1'b0;
    imemory_rdata = nop_word;
    errors = 0;
    timed_out = 1'b0;
    load_program();
    repeat (5) begin
      @(posedge clock);
      @(negedge clock);
      assert (!imemory_valid && !retire_valid) else begin
        errors++;
        $display("A request or a retire was seen during reset at %0t", $time);
      end
    end
    rst = 1'b0;

    cycles = 0;
    @(negedge clock);
    while (!imemory_valid && cycles < wait_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!imemory_valid) begin
      timed_out = 1'b1;
      errors++;
      $display("No fetch request was made within %0d cycles after reset", wait_limit);
    end else begin
      compare_field("first request address", imemory_addr, start_addr);
    end

    for (int i = 0; i < program_table.size() && !timed_out; i++) begin
      cycles = 0;
      @(negedge clock);
      while (!retire_valid && cycles < wait_limit) begin
        @(negedge clock);
        cycles++;
      end
      if (!retire_valid) begin
        timed_out = 1'b1;
        errors++;
        $display("No instruction retired within %0d cycles while waiting for retire %0d",
                 wait_limit, i);
      end else begin
        check_retire(i);
      end
    end

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/cpu.sv
dv/cpu_properties.sv
dv/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
